// ==== hdl/cart_pkg.sv ====
//**********************************************************
// Cartridge types, mapper phases and SDRAM layout constants
// shared by the bank mapper and its testbench
//**********************************************************

package cart_pkg;

	// Cartridge IDs as delivered on cart_id by the CRT loader
	typedef enum logic [15:0] {
		cart_generic    = 16'd0,
		cart_ocean      = 16'd5,
		cart_c64gs      = 16'd15,
		cart_magic_desk = 16'd19,
		cart_easyflash  = 16'd32
	} cart_type_e;

	// Mapper life cycle after reset or a cartridge change
	typedef enum logic [1:0] {
		mapper_reset,   // Registers held at reset values
		mapper_init,    // Boot state of the type is loaded
		mapper_run      // Normal bank switching
	} mapper_phase_e;

	//**********************************************************
	// Bank and address geometry
	//**********************************************************

	localparam int BANK_W   = 7;  // Up to 128 banks of 8k
	localparam int SDRAM_AW = 23;
	localparam int PAGE_W   = 13; // Offset inside one 8k bank

	// ROM banks start at 0x100000, 1MB max
	localparam logic [0:0] ROM_REGION = 1'b1;

	// RAM banks start at 0x010000, 64k max
	localparam logic [4:0] RAM_REGION = 5'b00001;

	// Chunks per table, enough for a 512k cartridge
	localparam int TABLE_DEPTH_DEFAULT = 64;

endpackage

// ==== hdl/bus_pkg.sv ====
//**********************************************************
// Bus bundles between the CPU side, the CRT loader and the
// window blocks of the bank mapper
//**********************************************************

package bus_pkg;

	// One CPU access as seen at the expansion port
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;
		logic        mem_ce;
		logic        rom_lo;   // $8000-$9FFF
		logic        rom_hi;   // $A000-$BFFF or $E000-$FFFF
		logic        io_e;     // $DExx
		logic        io_f;     // $DFxx
	} cpu_access_t;

	// CHIP packet header, wr pulses once per chunk
	typedef struct packed {
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
		logic [cart_pkg::SDRAM_AW-1:0] sdram_addr;
		logic        wr;
	} chunk_hdr_t;

	// Per window setup from the control block
	typedef struct packed {
		logic [cart_pkg::BANK_W-1:0] bank;
		logic rd_en;
		logic wr_en;
		logic ram;      // Map into the RAM region instead of ROM
	} window_cfg_t;

	typedef struct packed {
		logic hit;
		logic ce_pulse;
		logic [cart_pkg::SDRAM_AW-cart_pkg::PAGE_W-1:0] sdram_bank; // Address bits 22:13
	} window_res_t;

	// Windows in priority order, lowest first
	typedef enum logic [1:0] {
		win_rom_hi,
		win_rom_lo,
		win_io_e,
		win_io_f
	} window_idx_e;

endpackage

// ==== hdl/bank_table.sv ====
//**********************************************************
// Low and high bank tables built while the CRT file loads,
// read back combinationally by the mapper control
//**********************************************************

module bank_table #(
	parameter int TABLE_DEPTH = 64
) (
	input  logic                        clk32,
	input  logic                        cart_loading,
	input  bus_pkg::chunk_hdr_t         chunk,
	input  logic [5:0]                  rd_index,
	output logic [cart_pkg::BANK_W-1:0] lo_bank,
	output logic [cart_pkg::BANK_W-1:0] hi_bank,
	output logic [7:0]                  chunk_count
);

	localparam int IDX_W = $clog2(TABLE_DEPTH);

	logic [cart_pkg::BANK_W-1:0] lo_tab [TABLE_DEPTH];
	logic [cart_pkg::BANK_W-1:0] hi_tab [TABLE_DEPTH];

	logic                        old_loading;
	logic [IDX_W-1:0]            wr_idx;
	logic [IDX_W-1:0]            rd_sel;
	logic [cart_pkg::BANK_W-1:0] chunk_bank;

	assign wr_idx = chunk.bank_num[IDX_W-1:0];
	assign rd_sel = IDX_W'(rd_index);   // Fit the 6-bit index to the table size

	// 8k page of the chunk inside the SDRAM image
	assign chunk_bank = chunk.sdram_addr[cart_pkg::PAGE_W+cart_pkg::BANK_W-1:cart_pkg::PAGE_W];

	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;

		if (cart_loading && !old_loading)
			chunk_count <= 8'd0;    // New file, start counting again

		if (chunk.wr) begin
			chunk_count <= chunk_count + 8'd1;
			if (chunk.bank_num < TABLE_DEPTH) begin
				if (chunk.load_addr <= 16'h8000) begin
					lo_tab[wr_idx] <= chunk_bank;
					// 16k chunk also covers ROMH
					if (chunk.size > 16'h2000)
						hi_tab[wr_idx] <= chunk_bank + 1'b1;
				end else begin
					hi_tab[wr_idx] <= chunk_bank;   // Loaded at $A000 or $E000
				end
			end
		end
	end

	assign lo_bank = lo_tab[rd_sel];
	assign hi_bank = hi_tab[rd_sel];

endmodule

// ==== hdl/mapper_control.sv ====
//**********************************************************
// Per-cartridge control registers that drive EXROM/GAME and
// the bank and enable setup of the four memory windows
//**********************************************************

module mapper_control (
	input  logic                        clk32,
	input  logic                        reset_n,
	input  logic [15:0]                 cart_id,
	input  logic [7:0]                  cart_exrom,
	input  logic [7:0]                  cart_game,
	input  bus_pkg::chunk_hdr_t         chunk,
	input  bus_pkg::cpu_access_t        cpu,
	input  logic                        io_e_stb,
	input  logic                        io_f_stb,
	input  logic [cart_pkg::BANK_W-1:0] lo_bank,
	input  logic [cart_pkg::BANK_W-1:0] hi_bank,
	input  logic [7:0]                  chunk_count,
	output logic [5:0]                  rd_index,
	output bus_pkg::window_cfg_t        win_cfg [4],
	output logic                        exrom,
	output logic                        game
);

	localparam int ROM_HI = int'(bus_pkg::win_rom_hi);
	localparam int ROM_LO = int'(bus_pkg::win_rom_lo);
	localparam int IO_F   = int'(bus_pkg::win_io_f);

	logic [15:0]             old_id;
	cart_pkg::mapper_phase_e phase_q;
	cart_pkg::mapper_phase_e phase;
	logic                    boot;
	logic                    io1_wr;
	logic                    io1_rd;
	logic                    ef_bank_wr;

	// IO1 strobe counts only while IO2 is quiet
	assign io1_wr = io_e_stb & ~io_f_stb & cpu.write;
	assign io1_rd = io_e_stb & ~io_f_stb & ~cpu.write;

	// A new cartridge type restarts the mapper like a reset
	assign phase = (reset_n || (old_id != cart_id)) ? cart_pkg::mapper_reset : phase_q;
	assign boot  = (phase == cart_pkg::mapper_init);

	// EasyFlash bank register write looks up the table directly
	assign ef_bank_wr = (cart_id == cart_pkg::cart_easyflash) & io1_wr & ~cpu.addr[1];
	assign rd_index   = ef_bank_wr ? cpu.data[5:0] : 6'd0;

	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		if (phase == cart_pkg::mapper_reset)
			phase_q <= cart_pkg::mapper_init;
		else
			phase_q <= cart_pkg::mapper_run;
	end

	//**********************************************************
	// Control registers per cartridge type
	//**********************************************************

	always_ff @(posedge clk32) begin
		if (phase == cart_pkg::mapper_reset) begin
			exrom <= 1'b1;  // Cartridge invisible
			game  <= 1'b1;
			for (int i = 0; i < 4; i++)
				win_cfg[i] <= '0;
		end else begin
			case (cart_id)

				// Lines straight from the CRT header with a single bank
				cart_pkg::cart_generic: begin
					exrom                 <= cart_exrom[0];
					game                  <= cart_game[0];
					win_cfg[ROM_LO].bank  <= lo_bank;
					win_cfg[ROM_HI].bank  <= hi_bank;
					win_cfg[ROM_LO].rd_en <= 1'b1;
					win_cfg[ROM_HI].rd_en <= 1'b1;
				end

				// Ocean type 1 mirrors one bank at $8000 and $A000
				cart_pkg::cart_ocean: begin
					if (boot) begin
						exrom                 <= 1'b0;
						game                  <= 1'b0;
						win_cfg[ROM_LO].rd_en <= 1'b1;
						win_cfg[ROM_HI].rd_en <= 1'b1;
					end
					if (io1_wr) begin
						win_cfg[ROM_LO].bank <= {1'b0, cpu.data[5:0]};
						win_cfg[ROM_HI].bank <= {1'b0, cpu.data[5:0]};
					end
					// 512k images only use ROML
					if (chunk.wr && chunk.bank_num >= 16'd32)
						game <= 1'b1;
				end

				// C64GS stays in 8k mode
				cart_pkg::cart_c64gs: begin
					exrom <= 1'b0;
					game  <= 1'b1;
					if (boot) begin
						win_cfg[ROM_LO].rd_en <= 1'b1;
						win_cfg[ROM_HI].rd_en <= 1'b1;
					end
					if (io1_rd)
						win_cfg[ROM_LO].bank <= '0;
					if (io1_wr)
						win_cfg[ROM_LO].bank <= {1'b0, cpu.addr[5:0]};  // Bank from address
				end

				cart_pkg::cart_magic_desk: begin
					if (boot) begin
						exrom                 <= 1'b0;
						game                  <= 1'b1;
						win_cfg[ROM_LO].bank  <= '0;
						win_cfg[ROM_LO].rd_en <= 1'b1;
						win_cfg[ROM_HI].rd_en <= 1'b1;
					end
					if (io1_wr) begin
						// Bank bits limited by the image size
						if (chunk_count <= 8'd16)
							win_cfg[ROM_LO].bank <= {3'd0, cpu.data[3:0]};
						else if (chunk_count <= 8'd32)
							win_cfg[ROM_LO].bank <= {2'd0, cpu.data[4:0]};
						else if (chunk_count <= 8'd64)
							win_cfg[ROM_LO].bank <= {1'b0, cpu.data[5:0]};
						else
							win_cfg[ROM_LO].bank <= cpu.data[6:0];
						exrom <= cpu.data[7];   // Bit 7 switches the cartridge off
					end
				end

				// EasyFlash boots in Ultimax with 256 bytes of RAM at $DFxx
				cart_pkg::cart_easyflash: begin
					if (boot) begin
						exrom                 <= 1'b1;
						game                  <= 1'b0;
						win_cfg[ROM_LO].bank  <= lo_bank;
						win_cfg[ROM_HI].bank  <= hi_bank;
						win_cfg[ROM_LO].rd_en <= 1'b1;
						win_cfg[ROM_HI].rd_en <= 1'b1;
						win_cfg[IO_F].bank    <= '0;
						win_cfg[IO_F].rd_en   <= 1'b1;
						win_cfg[IO_F].wr_en   <= 1'b1;
						win_cfg[IO_F].ram     <= 1'b1;
					end
					if (io1_wr) begin
						if (cpu.addr[1]) begin
							// Boot jumper assumed in boot position
							game  <= ~cpu.data[0] & cpu.data[2];
							exrom <= ~cpu.data[1];
						end else begin
							win_cfg[ROM_LO].bank <= lo_bank;   // Entry picked by rd_index
							win_cfg[ROM_HI].bank <= hi_bank;
						end
					end
				end

				default: begin
					// Unknown types hold the reset values
				end
			endcase
		end
	end

endmodule

// ==== hdl/window_map.sv ====
//**********************************************************
// One cartridge memory window, gives hit, strobe and the
// SDRAM bank field for the address selector
//**********************************************************

module window_map (
	input  logic                 clk32,
	input  logic                 sel,
	input  logic                 write,
	input  bus_pkg::window_cfg_t cfg,
	input  logic                 is_io,
	output bus_pkg::window_res_t res
);

	logic sel_d;
	logic sel_rise;
	logic dir_en;

	always_ff @(posedge clk32) begin
		sel_d <= sel;
	end

	assign sel_rise = sel & ~sel_d;    // First cycle of the access

	// Enable for the direction of the current access
	assign dir_en = write ? cfg.wr_en : cfg.rd_en;

	always_comb begin
		res.hit = sel & dir_en;

		// ROM windows ride on the CPU's own mem_ce, only IO makes a strobe
		res.ce_pulse = is_io & sel_rise;

		if (cfg.ram)
			res.sdram_bank = {2'b00, cart_pkg::RAM_REGION, cfg.bank[2:0]};   // 8 RAM banks
		else
			res.sdram_bank = {2'b00, cart_pkg::ROM_REGION, cfg.bank};
	end

endmodule

// ==== hdl/address_select.sv ====
//**********************************************************
// Merges the window results into the SDRAM address and the
// memory strobes, highest priority window wins
//**********************************************************

module address_select (
	input  bus_pkg::cpu_access_t          cpu,
	input  bus_pkg::window_res_t          res [4],
	input  logic                          rom_lo_wr_en,
	input  logic                          exrom,
	input  logic                          game,
	input  logic                          reset_n,
	output logic [cart_pkg::SDRAM_AW-1:0] addr_out,
	output logic                          mem_ce_out,
	output logic                          mem_write_out,
	output logic                          io_rom
);

	localparam int IO_E = int'(bus_pkg::win_io_e);
	localparam int IO_F = int'(bus_pkg::win_io_f);

	logic io_hit;
	logic ultimax_lo;

	//**********************************************************
	// Address relocation
	//**********************************************************

	always_comb begin
		addr_out = {{(cart_pkg::SDRAM_AW-16){1'b0}}, cpu.addr};
		if (!reset_n) begin
			// Later windows overwrite earlier ones
			for (int i = 0; i < 4; i++) begin
				if (res[i].hit)
					addr_out[cart_pkg::SDRAM_AW-1:cart_pkg::PAGE_W] = res[i].sdram_bank;
			end
		end
	end

	assign io_hit = res[IO_E].hit | res[IO_F].hit;

	assign mem_ce_out = cpu.mem_ce
		| (res[IO_E].hit & res[IO_E].ce_pulse)
		| (res[IO_F].hit & res[IO_F].ce_pulse);

	// Ultimax ROML write would land in RAM that is not there
	assign ultimax_lo    = cpu.rom_lo & ~rom_lo_wr_en & exrom & ~game;
	assign mem_write_out = cpu.write & ~ultimax_lo;

	assign io_rom = io_hit & ~cpu.write; // IO area read from SDRAM

endmodule

// ==== hdl/cartridge_top.sv ====
//**********************************************************
// C64 cartridge bank mapper top level, instantiate with the
// CRT loader on chunk and the CPU port on cpu
//**********************************************************

module cartridge_top #(
	parameter int TABLE_DEPTH = cart_pkg::TABLE_DEPTH_DEFAULT
) (
	input  logic                          clk32,
	input  logic                          reset_n,
	input  logic                          cart_loading,
	input  logic [15:0]                   cart_id,
	input  logic [7:0]                    cart_exrom,
	input  logic [7:0]                    cart_game,
	input  bus_pkg::chunk_hdr_t           chunk,
	input  bus_pkg::cpu_access_t          cpu,
	output logic                          exrom,
	output logic                          game,
	output logic [cart_pkg::SDRAM_AW-1:0] addr_out,
	output logic                          mem_ce_out,
	output logic                          mem_write_out,
	output logic                          io_rom
);

	logic [5:0]                  rd_index;
	logic [cart_pkg::BANK_W-1:0] lo_bank;
	logic [cart_pkg::BANK_W-1:0] hi_bank;
	logic [7:0]                  chunk_count;
	logic [3:0]                  win_sel;
	bus_pkg::window_cfg_t        win_cfg [4];
	bus_pkg::window_res_t        win_res [4];

	// Selects laid out in window priority order
	assign win_sel[bus_pkg::win_rom_hi] = cpu.rom_hi;
	assign win_sel[bus_pkg::win_rom_lo] = cpu.rom_lo;
	assign win_sel[bus_pkg::win_io_e]   = cpu.io_e;
	assign win_sel[bus_pkg::win_io_f]   = cpu.io_f;

	bank_table #(.TABLE_DEPTH(TABLE_DEPTH)) bank_table_i (
		.clk32        (clk32),
		.cart_loading (cart_loading),
		.chunk        (chunk),
		.rd_index     (rd_index),
		.lo_bank      (lo_bank),
		.hi_bank      (hi_bank),
		.chunk_count  (chunk_count)
	);

	mapper_control mapper_control_i (
		.clk32       (clk32),
		.reset_n     (reset_n),
		.cart_id     (cart_id),
		.cart_exrom  (cart_exrom),
		.cart_game   (cart_game),
		.chunk       (chunk),
		.cpu         (cpu),
		.io_e_stb    (win_res[bus_pkg::win_io_e].ce_pulse),
		.io_f_stb    (win_res[bus_pkg::win_io_f].ce_pulse),
		.lo_bank     (lo_bank),
		.hi_bank     (hi_bank),
		.chunk_count (chunk_count),
		.rd_index    (rd_index),
		.win_cfg     (win_cfg),
		.exrom       (exrom),
		.game        (game)
	);

	//**********************************************************
	// Memory windows, the IO pair last
	//**********************************************************

	for (genvar w = 0; w < 4; w++) begin : g_window
		window_map window_map_i (
			.clk32 (clk32),
			.sel   (win_sel[w]),
			.write (cpu.write),
			.cfg   (win_cfg[w]),
			.is_io (w >= int'(bus_pkg::win_io_e)),
			.res   (win_res[w])
		);
	end

	address_select address_select_i (
		.cpu           (cpu),
		.res           (win_res),
		.rom_lo_wr_en  (win_cfg[bus_pkg::win_rom_lo].wr_en),
		.exrom         (exrom),
		.game          (game),
		.reset_n       (reset_n),
		.addr_out      (addr_out),
		.mem_ce_out    (mem_ce_out),
		.mem_write_out (mem_write_out),
		.io_rom        (io_rom)
	);

endmodule

// ==== verification/tb_clock.sv ====
//**********************************************************
// Testbench clock and reset, 8 ns period with 16 cycles of
// reset held high from time zero
//**********************************************************

module tb_clock (
	output logic clk32,
	output logic reset_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk32   = 1'b0;
		reset_n = 1'b1;                 // Reset is active high
		forever #4 clk32 = ~clk32;
	end

	initial begin
		repeat (16) @(posedge clk32);
		reset_n <= 1'b0;
	end

endmodule

// ==== verification/tb_cartridge.sv ====
//**********************************************************
// Testbench for the cartridge mapper with LFSR driven accesses
// checked against a reference model of the bank rules
//**********************************************************

module tb_cartridge;

	timeunit 1ns;
	timeprecision 100ps;

	// Cycle budget of the test sequence below
	localparam int ACCESSES       = 100 + 60 + 20 + 60 + 4 * 30 + 120 + 2 + 50;
	localparam int CHUNKS         = 64 + 8 + 10 + 20 + 40 + 70;
	localparam int LOADS          = 6;
	localparam int TYPES          = 5;
	localparam int PLANNED_CYCLES = 16 + 2 * ACCESSES + CHUNKS + 3 * LOADS + 3 * TYPES;

	logic                 clk32;
	logic                 reset_n;
	logic                 cart_loading;
	logic [15:0]          cart_id;
	logic [7:0]           cart_exrom;
	logic [7:0]           cart_game;
	bus_pkg::chunk_hdr_t  chunk;
	bus_pkg::cpu_access_t cpu;
	logic                 exrom;
	logic                 game;
	logic [22:0]          addr_out;
	logic                 mem_ce_out;
	logic                 mem_write_out;
	logic                 io_rom;

	// Reference model state with windows ordered rom_hi rom_lo io_e io_f
	logic [6:0]  tab_lo [64];
	logic [6:0]  tab_hi [64];
	logic [7:0]  m_count;
	logic [15:0] m_type;
	logic        m_exrom;
	logic        m_game;
	logic [6:0]  m_bank [4];
	logic        m_rd [4];
	logic        m_wr [4];
	logic        m_ram [4];
	logic [31:0] lfsr;
	int          errors;

	tb_clock tb_clock_i (.clk32(clk32), .reset_n(reset_n));

	cartridge_top #(.TABLE_DEPTH(cart_pkg::TABLE_DEPTH_DEFAULT)) cartridge_top_i (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading),
		.cart_id(cart_id), .cart_exrom(cart_exrom), .cart_game(cart_game),
		.chunk(chunk), .cpu(cpu), .exrom(exrom), .game(game),
		.addr_out(addr_out), .mem_ce_out(mem_ce_out),
		.mem_write_out(mem_write_out), .io_rom(io_rom)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic idle_cpu();
		cpu = '0;
	endtask

	//**********************************************************
	// Model updates
	//**********************************************************

	task automatic model_boot(input logic [15:0] t);
		m_type  = t;
		m_exrom = 1'b1;
		m_game  = 1'b1;
		for (int i = 0; i < 4; i++) begin
			m_bank[i] = '0;
			m_rd[i]   = 1'b0;
			m_wr[i]   = 1'b0;
			m_ram[i]  = 1'b0;
		end
		if (t inside {cart_pkg::cart_generic, cart_pkg::cart_ocean, cart_pkg::cart_c64gs,
				cart_pkg::cart_magic_desk, cart_pkg::cart_easyflash}) begin
			m_rd[0] = 1'b1;
			m_rd[1] = 1'b1;
		end
		case (t)
			cart_pkg::cart_generic: begin
				m_exrom   = cart_exrom[0];
				m_game    = cart_game[0];
				m_bank[0] = tab_hi[0];
				m_bank[1] = tab_lo[0];
			end
			cart_pkg::cart_ocean: begin
				m_exrom = 1'b0;
				m_game  = 1'b0;
			end
			cart_pkg::cart_c64gs, cart_pkg::cart_magic_desk: m_exrom = 1'b0;
			cart_pkg::cart_easyflash: begin
				m_game    = 1'b0;
				m_bank[0] = tab_hi[0];
				m_bank[1] = tab_lo[0];
				m_rd[3]   = 1'b1;   // 256 bytes of RAM at $DFxx
				m_wr[3]   = 1'b1;
				m_ram[3]  = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic model_io1(input logic wr, input logic [15:0] a, input logic [7:0] d);
		case (m_type)
			cart_pkg::cart_ocean:
				if (wr) begin
					m_bank[0] = {1'b0, d[5:0]};
					m_bank[1] = {1'b0, d[5:0]};
				end
			cart_pkg::cart_c64gs:
				m_bank[1] = wr ? {1'b0, a[5:0]} : 7'd0;
			cart_pkg::cart_magic_desk:
				if (wr) begin
					if (m_count <= 16)      m_bank[1] = d[6:0] & 7'h0F;
					else if (m_count <= 32) m_bank[1] = d[6:0] & 7'h1F;
					else if (m_count <= 64) m_bank[1] = d[6:0] & 7'h3F;
					else                    m_bank[1] = d[6:0];
					m_exrom = d[7];
				end
			cart_pkg::cart_easyflash:
				if (wr && a[1]) begin
					m_game  = ~d[0] & d[2];
					m_exrom = ~d[1];
				end else if (wr) begin
					m_bank[1] = tab_lo[d[5:0]];
					m_bank[0] = tab_hi[d[5:0]];
				end
			default: ;
		endcase
	endtask

	//**********************************************************
	// Stimulus tasks
	//**********************************************************

	task automatic load_chunks(input int n, input logic full);
		logic [6:0] pg;
		@(negedge clk32);
		cart_loading = 1'b1;
		m_count      = 8'd0;
		for (int i = 0; i < n; i++) begin
			@(negedge clk32);
			chunk.wr         = 1'b1;
			chunk.sdram_addr = 23'(rand_bits(23));
			chunk.bank_num   = full ? 16'(i) : 16'(rand_bits(7));
			chunk.size       = (full || rand_bits(1)) ? 16'h4000 : 16'h2000;
			case (full ? 2'd0 : 2'(rand_bits(2)))
				2'd0: chunk.load_addr = 16'h8000;
				2'd1: chunk.load_addr = 16'hA000;
				2'd2: chunk.load_addr = 16'hE000;
				default: chunk.load_addr = 16'(rand_bits(16));
			endcase
			pg = chunk.sdram_addr[19:13];
			m_count++;
			if (chunk.bank_num < 64) begin
				if (chunk.load_addr <= 16'h8000) begin
					tab_lo[chunk.bank_num[5:0]] = pg;
					if (chunk.size > 16'h2000)
						tab_hi[chunk.bank_num[5:0]] = pg + 7'd1;
				end else begin
					tab_hi[chunk.bank_num[5:0]] = pg;
				end
			end
			if (m_type == cart_pkg::cart_ocean && chunk.bank_num >= 32)
				m_game = 1'b1;   // Large Ocean image
		end
		@(negedge clk32);
		chunk        = '0;
		cart_loading = 1'b0;
		@(negedge clk32);
		if (m_type == cart_pkg::cart_generic) begin
			m_bank[0] = tab_hi[0];
			m_bank[1] = tab_lo[0];
		end
	endtask

	task automatic set_type(input logic [15:0] t);
		@(negedge clk32);
		cart_id    = t;
		cpu.addr   = 16'h8000 | 16'(rand_bits(13));
		cpu.rom_lo = 1'b1;
		cpu.mem_ce = 1'b1;
		@(negedge clk32);
		#1;
		check("exrom", exrom, 1'b1);       // Mapper restarted by the new ID
		check("game", game, 1'b1);
		check("addr_out", addr_out, {7'd0, cpu.addr});
		check("mem_ce_out", mem_ce_out, 1'b1);
		idle_cpu();
		@(negedge clk32);
		model_boot(t);
	endtask

	task automatic run_access(input int win, input logic wr, input logic [15:0] a,
			input logic [7:0] d);
		logic        hit;
		logic [22:0] exp_addr;
		@(negedge clk32);
		cpu.addr   = a;
		cpu.data   = d;
		cpu.write  = wr;
		cpu.mem_ce = (win < 2);
		cpu.rom_hi = (win == 0);
		cpu.rom_lo = (win == 1);
		cpu.io_e   = (win == 2);
		cpu.io_f   = (win == 3);
		#1;
		hit      = wr ? m_wr[win] : m_rd[win];
		exp_addr = {7'd0, a};
		if (hit)
			exp_addr[22:13] = m_ram[win] ? {7'b0000001, m_bank[win][2:0]}
				: {3'b001, m_bank[win]};
		check("exrom", exrom, m_exrom);
		check("game", game, m_game);
		check("addr_out", addr_out, exp_addr);
		check("mem_ce_out", mem_ce_out, (win < 2) ? 1'b1 : hit);
		check("mem_write_out", mem_write_out,
			wr & ~(win == 1 && !m_wr[1] && m_exrom && !m_game));
		check("io_rom", io_rom, (win >= 2) && hit && !wr);
		@(negedge clk32);
		if (win == 2)
			model_io1(wr, a, d);
		idle_cpu();
	endtask

	task automatic random_accesses(input int n, input int max_win, input logic rom_wr);
		int          w;
		logic        wr;
		logic [15:0] a;
		for (int i = 0; i < n; i++) begin
			w  = int'(rand_bits(2)) % (max_win + 1);
			wr = 1'(rand_bits(1));
			case (w)
				0: a = 16'hA000 | 16'(rand_bits(13));
				1: a = 16'h8000 | 16'(rand_bits(13));
				2: a = 16'hDE00 | 16'(rand_bits(8));
				default: a = 16'hDF00 | 16'(rand_bits(8));
			endcase
			if (w < 2 && !rom_wr)
				wr = 1'b0;
			run_access(w, wr, a, 8'(rand_bits(8)));
		end
	endtask

	//**********************************************************
	// Test sequence
	//**********************************************************

	initial begin
		errors       = 0;
		lfsr         = 32'd10;
		cart_loading = 1'b0;
		cart_id      = cart_pkg::cart_generic;
		cart_exrom   = 8'(rand_bits(8));
		cart_game    = 8'(rand_bits(8));
		chunk        = '0;
		idle_cpu();
		m_count      = 8'd0;
		model_boot(cart_pkg::cart_generic);

		// Pass-through while reset is held
		repeat (3) @(negedge clk32);
		while (reset_n) begin
			cpu.addr   = 16'(rand_bits(16));
			cpu.rom_lo = 1'b1;
			cpu.mem_ce = 1'(rand_bits(1));
			#1;
			check("exrom", exrom, 1'b1);
			check("game", game, 1'b1);
			check("addr_out", addr_out, {7'd0, cpu.addr});
			check("mem_ce_out", mem_ce_out, cpu.mem_ce);
			@(negedge clk32);
		end
		idle_cpu();

		load_chunks(64, 1'b1);
		model_boot(cart_pkg::cart_generic);
		random_accesses(100, 1, 1'b0);

		set_type(cart_pkg::cart_ocean);
		random_accesses(60, 2, 1'b0);
		load_chunks(8, 1'b0);
		random_accesses(20, 2, 1'b0);

		set_type(cart_pkg::cart_c64gs);
		random_accesses(60, 2, 1'b0);

		set_type(cart_pkg::cart_magic_desk);
		load_chunks(10, 1'b0);
		random_accesses(30, 2, 1'b0);
		load_chunks(20, 1'b0);
		random_accesses(30, 2, 1'b0);
		load_chunks(40, 1'b0);
		random_accesses(30, 2, 1'b0);
		load_chunks(70, 1'b0);
		random_accesses(30, 2, 1'b0);

		set_type(cart_pkg::cart_easyflash);
		random_accesses(120, 3, 1'b1);
		run_access(2, 1'b1, 16'hDE02, 8'h00);   // Ultimax mode
		run_access(1, 1'b1, 16'h8123, 8'h5A);

		cart_exrom = 8'(rand_bits(8));
		cart_game  = 8'(rand_bits(8));
		set_type(cart_pkg::cart_generic);
		random_accesses(50, 1, 1'b0);

		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(8 * PLANNED_CYCLES * 2);
		$display("Timeout, the test sequence did not finish in time");
		$display("Checks failed");
		$fatal(1);
	end

endmodule

// ==== src.f ====
hdl/cart_pkg.sv
hdl/bus_pkg.sv
hdl/bank_table.sv
hdl/mapper_control.sv
hdl/window_map.sv
hdl/address_select.sv
hdl/cartridge_top.sv
verification/tb_clock.sv
verification/tb_cartridge.sv

// ==== Makefile ====
# Verilator build and run of the cartridge mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_cartridge
RTL_TOP   ?= cartridge_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
